/* forth_pkg.sv */
// Forth processor shared definitions
// Cell and address types, opcode set, stack commands and port structs

package forth_pkg;

	////////////////////////////////
	// Widths
	////////////////////////////////

	// Data cell
	parameter int CELL_W = 32;
	// Opcode field in the low bits of a cell
	parameter int OP_W = 16;
	// Program address, 256 cells
	parameter int PROG_ADDR_W = 8;

	typedef logic [CELL_W-1:0] cell_t;
	typedef logic [PROG_ADDR_W-1:0] prog_addr_t;

	////////////////////////////////
	// Opcodes
	////////////////////////////////

	// Plain opcodes first, then the four that take an operand cell
	typedef enum logic [OP_W-1:0] {
		nop, dup, drop, over,
		plus, minus, op_and, op_or,
		op_not, negate, equal, zero_equal,
		exit, emit, io_led, io_button,
		lit, branch, zero_branch, call
	} op_e;

	// One stack command per cycle
	typedef enum logic [2:0] {
		stk_hold,
		stk_push,
		stk_pop,
		stk_replace,
		stk_pop_replace
	} stack_op_e;

	////////////////////////////////
	// Port structs
	////////////////////////////////

	// Program memory load port
	typedef struct packed {
		logic we;
		prog_addr_t addr;
		cell_t data;
	} prog_load_t;

	// Byte request toward the transmitter
	typedef struct packed {
		logic req;
		logic [7:0] data;
	} tx_req_t;

	// Dev board LEDs, active low
	typedef struct packed {
		logic r;
		logic b;
		logic g;
	} led_t;

endpackage

/* forth_stack.sv */
// Circular stack with a wrapping pointer
// One command per cycle, top two entries visible combinationally
`timescale 1ns/1ps

module forth_stack #(
	parameter type payload_t = logic,
	parameter int depth = 16
) (
	input logic clk,
	input logic reset,
	input forth_pkg::stack_op_e op,
	input payload_t wdata,
	output payload_t top,
	output payload_t next
);
	import forth_pkg::*;

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	payload_t mem [depth];
	logic [ptr_w-1:0] ptr;
	logic [ptr_w-1:0] ptr_up;
	logic [ptr_w-1:0] ptr_down;

	// Neighbours of the top slot, wrap is intended
	assign ptr_up = ptr + 1'b1;
	assign ptr_down = ptr - 1'b1;

	assign top = mem[ptr];
	assign next = mem[ptr_down];

	// Pointer
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ptr <= '0;
		end else begin
			case (op)
				stk_push: ptr <= ptr_up;
				stk_pop, stk_pop_replace: ptr <= ptr_down;
				default: ptr <= ptr;
			endcase
		end
	end

	// Entry array
	always_ff @(posedge clk) begin
		case (op)
			stk_push: mem[ptr_up] <= wdata;
			stk_replace: mem[ptr] <= wdata;
			// Binary operators land on the new top
			stk_pop_replace: mem[ptr_down] <= wdata;
			default: ;
		endcase
	end

endmodule

/* forth_program_ram.sv */
// Program memory, 256 cells
// Write port from the load struct, registered fetch port
`timescale 1ns/1ps

module forth_program_ram (
	input logic clk,
	input forth_pkg::prog_load_t load,
	input forth_pkg::prog_addr_t fetch_addr,
	output forth_pkg::cell_t fetch_data
);
	import forth_pkg::*;

	cell_t mem [2**PROG_ADDR_W];

	// Load from the testbench side
	always_ff @(posedge clk) begin
		if (load.we) begin
			mem[load.addr] <= load.data;
		end
	end

	// Fetch, one cycle of latency
	always_ff @(posedge clk) begin
		fetch_data <= mem[fetch_addr];
	end

endmodule

/* forth_sequencer.sv */
// Inner interpreter of the Forth processor
// Fetch/execute FSM with ALU, LED register and button synchronizer
`timescale 1ns/1ps

module forth_sequencer (
	input logic clk,
	input logic reset,
	input logic run,
	input logic [1:0] buttons,
	output forth_pkg::prog_addr_t fetch_addr,
	input forth_pkg::cell_t fetch_data,
	output forth_pkg::stack_op_e dstk_op,
	output forth_pkg::cell_t dstk_wdata,
	input forth_pkg::cell_t dstk_top,
	input forth_pkg::cell_t dstk_next,
	output forth_pkg::stack_op_e rstk_op,
	output forth_pkg::prog_addr_t rstk_wdata,
	input forth_pkg::prog_addr_t rstk_top,
	output forth_pkg::tx_req_t tx_req,
	input logic tx_ack,
	output forth_pkg::led_t leds
);
	import forth_pkg::*;

	typedef enum logic [2:0] {
		idle,
		fetch,
		execute,
		operand,
		emit_wait_ack,
		emit_wait_release
	} seq_state_e;

	seq_state_e state;
	prog_addr_t pc;
	op_e opcode;
	op_e op_q;
	logic [1:0] btn_meta;
	logic [1:0] btn_sync;

	// RAM always looks at pc, data shows up a cycle later
	assign fetch_addr = pc;
	assign opcode = op_e'(fetch_data[OP_W-1:0]);

	// Two-flop button synchronizer
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= buttons;
			btn_sync <= btn_meta;
		end
	end

	////////////////////////////////
	// ALU and stack commands
	////////////////////////////////

	always_comb begin
		dstk_op = stk_hold;
		dstk_wdata = dstk_top;
		rstk_op = stk_hold;
		// Return address is the cell after the operand
		rstk_wdata = pc;
		if (state == execute) begin
			case (opcode)
				dup: begin
					dstk_op = stk_push;
					dstk_wdata = dstk_top;
				end
				over: begin
					dstk_op = stk_push;
					dstk_wdata = dstk_next;
				end
				drop, emit, io_led: dstk_op = stk_pop;
				plus: begin
					dstk_op = stk_pop_replace;
					dstk_wdata = dstk_next + dstk_top;
				end
				minus: begin
					dstk_op = stk_pop_replace;
					dstk_wdata = dstk_next - dstk_top;
				end
				op_and: begin
					dstk_op = stk_pop_replace;
					dstk_wdata = dstk_next & dstk_top;
				end
				op_or: begin
					dstk_op = stk_pop_replace;
					dstk_wdata = dstk_next | dstk_top;
				end
				op_not: begin
					dstk_op = stk_replace;
					dstk_wdata = ~dstk_top;
				end
				negate: begin
					dstk_op = stk_replace;
					dstk_wdata = -dstk_top;
				end
				// Flags are all ones or all zeros
				equal: begin
					dstk_op = stk_pop_replace;
					dstk_wdata = {CELL_W{dstk_next == dstk_top}};
				end
				zero_equal: begin
					dstk_op = stk_replace;
					dstk_wdata = {CELL_W{dstk_top == '0}};
				end
				io_button: begin
					dstk_op = stk_push;
					dstk_wdata = {{(CELL_W-2){1'b0}}, btn_sync};
				end
				exit: rstk_op = stk_pop;
				default: ;
			endcase
		end else if (state == operand) begin
			case (op_q)
				lit: begin
					dstk_op = stk_push;
					dstk_wdata = fetch_data;
				end
				zero_branch: dstk_op = stk_pop;
				call: rstk_op = stk_push;
				default: ;
			endcase
		end
	end

	////////////////////////////////
	// Fetch/execute FSM
	////////////////////////////////

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= idle;
			pc <= '0;
			op_q <= nop;
			tx_req <= '0;
			leds <= '1;
		end else if (!run && state != emit_wait_ack && state != emit_wait_release) begin
			// Handshake finishes first, then back to address 0
			state <= idle;
			pc <= '0;
		end else begin
			case (state)
				idle: state <= fetch;
				fetch: begin
					pc <= pc + 1'b1;
					state <= execute;
				end
				execute: begin
					op_q <= opcode;
					state <= fetch;
					case (opcode)
						lit, branch, zero_branch, call: begin
							// Step over the operand cell
							pc <= pc + 1'b1;
							state <= operand;
						end
						exit: pc <= rstk_top;
						emit: begin
							tx_req.req <= 1'b1;
							tx_req.data <= dstk_top[7:0];
							state <= emit_wait_ack;
						end
						io_led: begin
							leds.g <= ~dstk_top[0];
							leds.b <= ~dstk_top[1];
							leds.r <= ~dstk_top[2];
						end
						default: ;
					endcase
				end
				operand: begin
					state <= fetch;
					case (op_q)
						branch, call: pc <= fetch_data[PROG_ADDR_W-1:0];
						zero_branch: begin
							if (dstk_top == '0) begin
								pc <= fetch_data[PROG_ADDR_W-1:0];
							end
						end
						default: ;
					endcase
				end
				// Stalled until the frame is out
				emit_wait_ack: begin
					if (tx_ack) begin
						tx_req.req <= 1'b0;
						state <= emit_wait_release;
					end
				end
				emit_wait_release: begin
					if (!tx_ack) begin
						state <= fetch;
					end
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

/* uart_baud_timer.sv */
// UART bit period timer
// Pulses tick at the end of each bit period while enabled
`timescale 1ns/1ps

module uart_baud_timer #(
	parameter int clks_per_bit = 4
) (
	input logic clk,
	input logic reset,
	input logic enable,
	output logic tick
);

	localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

	logic [cnt_w-1:0] count;

	assign tick = enable && (count == cnt_w'(clks_per_bit - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= '0;
		end else if (!enable || tick) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

/* uart_tx.sv */
// UART transmitter, 8N1, LSB first, idle high
// Four-phase req/ack toward the sequencer
`timescale 1ns/1ps

module uart_tx #(
	parameter int clks_per_bit = 4
) (
	input logic clk,
	input logic reset,
	input forth_pkg::tx_req_t tx_req,
	output logic tx_ack,
	output logic tx
);

	typedef enum logic [1:0] {
		tx_idle,
		tx_send,
		tx_ack_hold
	} tx_state_e;

	tx_state_e state;
	// Stop bit, data, start bit
	logic [9:0] shift;
	logic [3:0] bit_cnt;
	logic tick;

	uart_baud_timer #(
		.clks_per_bit(clks_per_bit)
	) u_baud_timer (
		.clk(clk),
		.reset(reset),
		.enable(state == tx_send),
		.tick(tick)
	);

	assign tx = (state == tx_send) ? shift[0] : 1'b1;
	assign tx_ack = (state == tx_ack_hold);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= tx_idle;
			shift <= '1;
			bit_cnt <= '0;
		end else begin
			case (state)
				tx_idle: begin
					if (tx_req.req) begin
						shift <= {1'b1, tx_req.data, 1'b0};
						bit_cnt <= '0;
						state <= tx_send;
					end
				end
				tx_send: begin
					if (tick) begin
						// Ten bits per frame
						if (bit_cnt == 4'd9) begin
							state <= tx_ack_hold;
						end else begin
							shift <= {1'b1, shift[9:1]};
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				tx_ack_hold: begin
					if (!tx_req.req) begin
						state <= tx_idle;
					end
				end
				default: state <= tx_idle;
			endcase
		end
	end

endmodule

/* forth_top.sv */
// Forth processor top level
// Program memory, sequencer, data and return stacks, UART transmitter
`timescale 1ns/1ps

module forth_top #(
	parameter int data_depth = 16,
	parameter int return_depth = 8,
	parameter int clks_per_bit = 4
) (
	input logic clk,
	input logic reset,
	input forth_pkg::prog_load_t load,
	input logic run,
	input logic [1:0] buttons,
	output logic tx,
	output forth_pkg::led_t leds
);
	import forth_pkg::*;

	prog_addr_t fetch_addr;
	cell_t fetch_data;
	stack_op_e dstk_op;
	cell_t dstk_wdata;
	cell_t dstk_top;
	cell_t dstk_next;
	stack_op_e rstk_op;
	prog_addr_t rstk_wdata;
	prog_addr_t rstk_top;
	tx_req_t tx_req;
	logic tx_ack;

	forth_program_ram u_program_ram (
		.clk(clk),
		.load(load),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data)
	);

	forth_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.run(run),
		.buttons(buttons),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.dstk_op(dstk_op),
		.dstk_wdata(dstk_wdata),
		.dstk_top(dstk_top),
		.dstk_next(dstk_next),
		.rstk_op(rstk_op),
		.rstk_wdata(rstk_wdata),
		.rstk_top(rstk_top),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.leds(leds)
	);

	// Data cells
	forth_stack #(
		.payload_t(cell_t),
		.depth(data_depth)
	) u_data_stack (
		.clk(clk),
		.reset(reset),
		.op(dstk_op),
		.wdata(dstk_wdata),
		.top(dstk_top),
		.next(dstk_next)
	);

	// Return addresses, second entry never read
	forth_stack #(
		.payload_t(prog_addr_t),
		.depth(return_depth)
	) u_return_stack (
		.clk(clk),
		.reset(reset),
		.op(rstk_op),
		.wdata(rstk_wdata),
		.top(rstk_top),
		.next()
	);

	uart_tx #(
		.clks_per_bit(clks_per_bit)
	) u_uart_tx (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx(tx)
	);

endmodule

/* tb_clock_gen.sv */
// Testbench clock source
// Free-running clock, 40 ns period by default
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int period_ns = 40
) (
	output logic clk
);

	// Half period high, half period low
	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule

/* forth_assert.sv */
// UART transmitter handshake checks
// Four-phase req/ack rules and idle line level
`timescale 1ns/1ps

module forth_assert (
	input logic clk,
	input logic reset,
	input forth_pkg::tx_req_t tx_req,
	input logic tx_ack,
	input logic tx
);

	// Read back by the testbench at the end of the run
	int fail_count = 0;

	//////////////////////////////
	// Handshake
	//////////////////////////////

	// Request and byte frozen until the frame is acknowledged
	property req_held_stable;
		@(posedge clk) disable iff (!reset)
		(tx_req.req && !tx_ack) |=> $stable(tx_req);
	endproperty

	// Ack only answers a live request
	property ack_needs_req;
		@(posedge clk) disable iff (!reset)
		$rose(tx_ack) |-> tx_req.req;
	endproperty

	// Both sides low means the transmitter is idle
	property idle_line_high;
		@(posedge clk) disable iff (!reset)
		(!tx_req.req && !tx_ack) |-> tx;
	endproperty

	a_req_held_stable: assert property (req_held_stable) else begin
		fail_count++;
		$error("tx_req changed while waiting for ack");
	end

	a_ack_needs_req: assert property (ack_needs_req) else begin
		fail_count++;
		$error("tx_ack rose without a request");
	end

	a_idle_line_high: assert property (idle_line_high) else begin
		fail_count++;
		$error("tx line low while transmitter idle");
	end

endmodule

/* forth_tb.sv */
// Directed tests for the Forth processor
// Loads programs, decodes the UART line and checks bytes and LEDs
`timescale 1ns/1ps

module forth_tb;
	import forth_pkg::*;

	localparam int clks_per_bit = 4;
	// Cycles allowed for one byte, program overhead included
	localparam int byte_timeout = 600;
	localparam int silence_cycles = 300;

	logic clk;
	logic reset;
	logic run;
	logic [1:0] buttons;
	prog_load_t load;
	logic tx;
	led_t leds;

	cell_t prog_image[$];
	logic [7:0] expected[$];
	int errors = 0;
	int checks = 0;
	int test_err_start = 0;

	tb_clock_gen #(
		.period_ns(40)
	) u_clock_gen (
		.clk(clk)
	);

	forth_top #(
		.data_depth(16),
		.return_depth(8),
		.clks_per_bit(clks_per_bit)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.load(load),
		.run(run),
		.buttons(buttons),
		.tx(tx),
		.leds(leds)
	);

	// Handshake checks inside the transmitter
	bind uart_tx forth_assert u_tx_assert (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx(tx)
	);

	//////////////////////////////
	// Checks and bookkeeping
	//////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	task automatic start_test();
		prog_image.delete();
		expected.delete();
		test_err_start = errors;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_err_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - test_err_start);
		end
	endtask

	//////////////////////////////
	// Program building
	//////////////////////////////

	task automatic add_op(input op_e op);
		prog_image.push_back(cell_t'(op));
	endtask

	// Opcode followed by its operand cell
	task automatic add_op_arg(input op_e op, input cell_t arg);
		prog_image.push_back(cell_t'(op));
		prog_image.push_back(arg);
	endtask

	// Branch to itself
	task automatic add_halt();
		add_op_arg(branch, cell_t'(prog_image.size()));
	endtask

	//////////////////////////////
	// DUT driving
	//////////////////////////////

	task automatic apply_reset();
		repeat (3) @(posedge clk);
		reset <= 1'b1;
	endtask

	// Stop, write the image from address 0, start again
	task automatic load_program();
		@(posedge clk);
		run <= 1'b0;
		foreach (prog_image[i]) begin
			@(posedge clk);
			load.we <= 1'b1;
			load.addr <= prog_addr_t'(i);
			load.data <= prog_image[i];
		end
		@(posedge clk);
		load.we <= 1'b0;
		@(posedge clk);
		run <= 1'b1;
	endtask

	//////////////////////////////
	// UART receiver model
	//////////////////////////////

	// Samples on falling edges, near the middle of each bit
	task automatic receive_byte(output logic [7:0] data, output bit ok);
		int wait_cnt;
		ok = 1'b0;
		data = '0;
		wait_cnt = 0;
		do begin
			@(negedge clk);
			wait_cnt++;
		end while (tx !== 1'b0 && wait_cnt < byte_timeout);
		if (tx !== 1'b0) begin
			report_failure("no start bit on tx before timeout");
			return;
		end
		repeat (clks_per_bit / 2) @(negedge clk);
		if (tx !== 1'b0) begin
			report_failure("start bit on tx ended early");
			return;
		end
		// LSB first
		for (int i = 0; i < 8; i++) begin
			repeat (clks_per_bit) @(negedge clk);
			data[i] = tx;
		end
		repeat (clks_per_bit) @(negedge clk);
		if (tx !== 1'b1) begin
			report_failure("stop bit on tx is low");
			return;
		end
		ok = 1'b1;
	endtask

	task automatic receive_expected();
		logic [7:0] got;
		bit ok;
		foreach (expected[i]) begin
			receive_byte(got, ok);
			if (ok) begin
				check_value("tx byte", 32'(got), 32'(expected[i]));
			end
		end
	endtask

	task automatic expect_silence(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (tx !== 1'b1) begin
				report_failure("unexpected frame started on tx");
				return;
			end
		end
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_emit_literals();
		logic [7:0] b;
		start_test();
		// Printable ASCII only
		for (int i = 0; i < 3; i++) begin
			b = 8'($urandom_range(126, 32));
			add_op_arg(lit, cell_t'(b));
			add_op(emit);
			expected.push_back(b);
		end
		add_halt();
		load_program();
		receive_expected();
		finish_test("emit and literals");
	endtask

	task automatic test_alu();
		cell_t a;
		cell_t b;
		cell_t x;
		cell_t y;
		start_test();
		a = $urandom();
		b = $urandom();
		x = $urandom();
		y = $urandom();
		// Binary operators, second operand on top
		add_op_arg(lit, a);
		add_op_arg(lit, b);
		add_op(plus);
		add_op(emit);
		expected.push_back(8'(a + b));
		add_op_arg(lit, a);
		add_op_arg(lit, b);
		add_op(minus);
		add_op(emit);
		expected.push_back(8'(a - b));
		add_op_arg(lit, a);
		add_op_arg(lit, b);
		add_op(op_and);
		add_op(emit);
		expected.push_back(8'(a & b));
		add_op_arg(lit, a);
		add_op_arg(lit, b);
		add_op(op_or);
		add_op(emit);
		expected.push_back(8'(a | b));
		// Unary
		add_op_arg(lit, a);
		add_op(op_not);
		add_op(emit);
		expected.push_back(8'(~a));
		add_op_arg(lit, b);
		add_op(negate);
		add_op(emit);
		expected.push_back(8'(0 - b));
		// Flags, true then false
		add_op_arg(lit, a);
		add_op_arg(lit, a);
		add_op(equal);
		add_op(emit);
		expected.push_back(8'hff);
		add_op_arg(lit, a);
		add_op_arg(lit, a ^ 32'h0000_0100);
		add_op(equal);
		add_op(emit);
		expected.push_back(8'h00);
		add_op_arg(lit, '0);
		add_op(zero_equal);
		add_op(emit);
		expected.push_back(8'hff);
		add_op_arg(lit, a | 32'h1);
		add_op(zero_equal);
		add_op(emit);
		expected.push_back(8'h00);
		// Stack shuffles
		add_op_arg(lit, x);
		add_op(dup);
		add_op(emit);
		add_op(emit);
		expected.push_back(8'(x));
		expected.push_back(8'(x));
		add_op_arg(lit, x);
		add_op_arg(lit, y);
		add_op(over);
		add_op(emit);
		add_op(emit);
		add_op(emit);
		expected.push_back(8'(x));
		expected.push_back(8'(y));
		expected.push_back(8'(x));
		add_op_arg(lit, x);
		add_op_arg(lit, y);
		add_op(drop);
		add_op(emit);
		expected.push_back(8'(x));
		add_halt();
		load_program();
		receive_expected();
		finish_test("arithmetic and logic");
	endtask

	task automatic test_branch_loop();
		int count;
		int loop_addr;
		start_test();
		count = $urandom_range(6, 3);
		add_op_arg(lit, cell_t'(count));
		loop_addr = prog_image.size();
		add_op(dup);
		add_op(emit);
		add_op_arg(lit, 32'd1);
		add_op(minus);
		add_op(dup);
		// Exit target sits after this branch pair and the loop-back branch
		add_op_arg(zero_branch, cell_t'(prog_image.size() + 4));
		add_op_arg(branch, cell_t'(loop_addr));
		add_halt();
		for (int v = count; v > 0; v--) begin
			expected.push_back(8'(v));
		end
		load_program();
		receive_expected();
		expect_silence(silence_cycles);
		finish_test("branching");
	endtask

	task automatic test_subroutine();
		cell_t sub_addr;
		int call_a;
		int call_b;
		start_test();
		add_op_arg(call, '0);
		call_a = prog_image.size() - 1;
		add_op_arg(lit, 32'h4d);
		add_op(emit);
		add_op_arg(call, '0);
		call_b = prog_image.size() - 1;
		add_halt();
		// Routine starts right after the halt
		sub_addr = cell_t'(prog_image.size());
		prog_image[call_a] = sub_addr;
		prog_image[call_b] = sub_addr;
		add_op_arg(lit, 32'h52);
		add_op(emit);
		add_op(exit);
		expected.push_back(8'h52);
		expected.push_back(8'h4d);
		expected.push_back(8'h52);
		load_program();
		receive_expected();
		finish_test("subroutine");
	endtask

	task automatic test_leds_buttons();
		logic [1:0] btn;
		logic [2:0] led_vals[3];
		logic [7:0] got;
		bit ok;
		led_t want_leds;
		start_test();
		btn = 2'($urandom_range(3, 0));
		@(posedge clk);
		buttons <= btn;
		// ASCII digit of the button value
		add_op(io_button);
		add_op_arg(lit, 32'd48);
		add_op(plus);
		add_op(emit);
		// Each LED value followed by a marker byte
		for (int i = 0; i < 3; i++) begin
			led_vals[i] = 3'($urandom_range(7, 0));
			add_op_arg(lit, cell_t'(led_vals[i]));
			add_op(io_led);
			add_op_arg(lit, cell_t'(8'h41 + i));
			add_op(emit);
		end
		add_halt();
		load_program();
		receive_byte(got, ok);
		if (ok) begin
			check_value("button byte", 32'(got), 32'(8'd48 + btn));
		end
		for (int i = 0; i < 3; i++) begin
			receive_byte(got, ok);
			if (ok) begin
				// Active low, three bits only
				want_leds = ~led_vals[i];
				check_value("marker byte", 32'(got), 32'(8'h41 + i));
				check_value("leds", 32'(leds), 32'(want_leds));
			end
		end
		finish_test("leds and buttons");
	endtask

	task automatic test_reset_mid_frame();
		int wait_cnt;
		start_test();
		// LEDs lit first so the reset value is visible
		add_op_arg(lit, 32'd2);
		add_op(io_led);
		add_op_arg(lit, 32'h5a);
		add_op(emit);
		add_halt();
		load_program();
		wait_cnt = 0;
		do begin
			@(negedge clk);
			wait_cnt++;
		end while (tx !== 1'b0 && wait_cnt < byte_timeout);
		if (tx !== 1'b0) begin
			report_failure("frame never started before mid-frame reset");
		end
		// A few bits into the frame
		repeat (3 * clks_per_bit) @(posedge clk);
		reset <= 1'b0;
		run <= 1'b0;
		for (int i = 0; i < 3; i++) begin
			@(negedge clk);
			check_value("tx in reset", 32'(tx), 32'd1);
			check_value("leds in reset", 32'(leds), 32'h7);
		end
		@(posedge clk);
		reset <= 1'b1;
		expect_silence(silence_cycles);
		finish_test("reset in mid-frame");
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		void'($urandom(32'h0944_c34c));
		reset <= 1'b0;
		run <= 1'b0;
		buttons <= '0;
		load <= '0;
		apply_reset();
		test_emit_literals();
		test_alu();
		test_branch_loop();
		test_subroutine();
		test_leds_buttons();
		test_reset_mid_frame();
		check_value("assertion failures", 32'(u_dut.u_uart_tx.u_tx_assert.fail_count), 32'd0);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
forth_pkg.sv
forth_stack.sv
forth_program_ram.sv
forth_sequencer.sv
uart_baud_timer.sv
uart_tx.sv
forth_top.sv
tb_clock_gen.sv
forth_assert.sv
forth_tb.sv

/* Makefile */
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = forth_tb
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = Simulation FAILED
PASS_MSG   = Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "sim: failure in $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "sim: run ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
